//--- hdl/core_exec_defs.svh
`ifndef CORE_EXEC_DEFS_SVH
`define CORE_EXEC_DEFS_SVH

// Operand and result word
`define CORE_DATA_WIDTH         32

// Destination register address
`define CORE_REG_ADDR_WIDTH     5

// Reorder buffer sizing
// Depth must stay a power of two so ids wrap on their own
`define CORE_ROB_ENTRIES        8
`define CORE_ROB_ID_WIDTH       3

// Cycles from an accepted MUL issue to its result
`define CORE_MUL_LATENCY        3

`endif

//--- hdl/core_exec_pkg.sv
`include "core_exec_defs.svh"

package core_exec_pkg;

    // Target execution unit
    typedef enum logic
    {
        EXEC_ALU = 1'b0,
        EXEC_MUL = 1'b1
    } exec_unit_t;

    // ALU operations
    // Shifts use the low five bits of src2, slt is a signed compare
    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // Decoded instruction as it enters the core
    typedef struct packed
    {
        exec_unit_t                         unit;
        alu_op_t                            op;
        logic   [`CORE_DATA_WIDTH-1:0]      src1;
        logic   [`CORE_DATA_WIDTH-1:0]      src2;
        logic   [`CORE_REG_ADDR_WIDTH-1:0]  dest;
    } issue_req_t;

    // Finished result from either unit
    typedef struct packed
    {
        logic   [`CORE_ROB_ID_WIDTH-1:0]    id;
        logic   [`CORE_REG_ADDR_WIDTH-1:0]  dest;
        logic   [`CORE_DATA_WIDTH-1:0]      data;
    } exec_result_t;

    // Retired instruction leaving the core
    typedef struct packed
    {
        logic   [`CORE_ROB_ID_WIDTH-1:0]    id;
        logic   [`CORE_REG_ADDR_WIDTH-1:0]  dest;
        logic   [`CORE_DATA_WIDTH-1:0]      data;
    } commit_t;

endpackage

//--- hdl/latency_pipe.sv
module latency_pipe
#(
    parameter type  payload_t = logic,
    parameter int   depth     = 1
)
(
    // System signals
    input   logic       clock,
    input   logic       reset,

    // Entry side
    input   logic       in_valid,
    input   payload_t   in_data,

    // Exit side
    output  logic       out_valid,
    output  payload_t   out_data
);

// One valid bit and one payload slot per stage
logic   [depth-1:0]     valid_q;
payload_t               data_q [depth];

// Valid chain, cleared on reset
always_ff @(posedge clock)
begin
    if (reset)
        valid_q <= '0;
    else
    begin
        valid_q[0] <= in_valid;
        for (int i = 1; i < depth; i++)
            valid_q[i] <= valid_q[i-1];
    end
end

// Payload only moves alongside a valid bit
always_ff @(posedge clock)
begin
    if (in_valid)
        data_q[0] <= in_data;
    for (int i = 1; i < depth; i++)
        if (valid_q[i-1])
            data_q[i] <= data_q[i-1];
end

// Last stage drives the outputs
assign out_valid = valid_q[depth-1];
assign out_data  = data_q[depth-1];

endmodule

//--- hdl/alu_unit.sv
`include "core_exec_defs.svh"

module alu_unit
(
    // System signals
    input   logic                               clock,
    input   logic                               reset,

    // Issue from the top level
    input   logic                               issue_valid,
    input   core_exec_pkg::issue_req_t          issue_info,
    input   logic   [`CORE_ROB_ID_WIDTH-1:0]    alloc_id,

    // Result to the reorder buffer
    output  logic                               result_valid,
    output  core_exec_pkg::exec_result_t        result
);

logic                               alu_req;
logic   [`CORE_DATA_WIDTH-1:0]      alu_data;
core_exec_pkg::exec_result_t        alu_out;

// Only requests that name this unit
assign alu_req = issue_valid && (issue_info.unit == core_exec_pkg::EXEC_ALU);

// Operation decode
always_comb
begin
    case (issue_info.op)
        core_exec_pkg::ALU_ADD: alu_data = issue_info.src1 + issue_info.src2;
        core_exec_pkg::ALU_SUB: alu_data = issue_info.src1 - issue_info.src2;
        core_exec_pkg::ALU_AND: alu_data = issue_info.src1 & issue_info.src2;
        core_exec_pkg::ALU_OR:  alu_data = issue_info.src1 | issue_info.src2;
        core_exec_pkg::ALU_XOR: alu_data = issue_info.src1 ^ issue_info.src2;
        // Shift amount masked to five bits
        core_exec_pkg::ALU_SLL: alu_data = issue_info.src1 << issue_info.src2[4:0];
        core_exec_pkg::ALU_SRL: alu_data = issue_info.src1 >> issue_info.src2[4:0];
        // Signed less-than gives 1 or 0
        core_exec_pkg::ALU_SLT: alu_data = {{(`CORE_DATA_WIDTH-1){1'b0}},
                                            ($signed(issue_info.src1)
                                             < $signed(issue_info.src2))};
        default:                alu_data = '0;
    endcase
end

// Tag with id and destination
always_comb
begin
    alu_out.id   = alloc_id;
    alu_out.dest = issue_info.dest;
    alu_out.data = alu_data;
end

// Single register stage, latency one
latency_pipe
#(
    .payload_t  ( core_exec_pkg::exec_result_t ),
    .depth      ( 1                            )
)
result_pipe
(
    .clock      ( clock         ),
    .reset      ( reset         ),
    .in_valid   ( alu_req       ),
    .in_data    ( alu_out       ),
    .out_valid  ( result_valid  ),
    .out_data   ( result        )
);

// All eight codes are defined, so only an unknown opcode falls outside the set
assert property (@(posedge clock) disable iff (reset)
    alu_req |-> !$isunknown(issue_info.op));

endmodule

//--- hdl/mul_unit.sv
`include "core_exec_defs.svh"

module mul_unit
(
    // System signals
    input   logic                               clock,
    input   logic                               reset,

    // Issue from the top level
    input   logic                               issue_valid,
    input   core_exec_pkg::issue_req_t          issue_info,
    input   logic   [`CORE_ROB_ID_WIDTH-1:0]    alloc_id,

    // Result to the reorder buffer
    output  logic                               result_valid,
    output  core_exec_pkg::exec_result_t        result
);

logic                               mul_req;
logic   [`CORE_DATA_WIDTH-1:0]      product_low;
logic                               stage_valid;
core_exec_pkg::exec_result_t        stage_result;

// Only requests that name this unit
assign mul_req = issue_valid && (issue_info.unit == core_exec_pkg::EXEC_MUL);

// Unsigned product, low word kept
assign product_low = issue_info.src1 * issue_info.src2;

// First stage, valid bit
always_ff @(posedge clock)
begin
    if (reset)
        stage_valid <= 1'b0;
    else
        stage_valid <= mul_req;
end

// First stage, payload
always_ff @(posedge clock)
begin
    if (mul_req)
    begin
        stage_result.id   <= alloc_id;
        stage_result.dest <= issue_info.dest;
        stage_result.data <= product_low;
    end
end

// Remaining latency, overlapping products in flight
latency_pipe
#(
    .payload_t  ( core_exec_pkg::exec_result_t ),
    .depth      ( `CORE_MUL_LATENCY - 1        )
)
result_pipe
(
    .clock      ( clock         ),
    .reset      ( reset         ),
    .in_valid   ( stage_valid   ),
    .in_data    ( stage_result  ),
    .out_valid  ( result_valid  ),
    .out_data   ( result        )
);

// Result appears exactly the fixed latency after issue
assert property (@(posedge clock) disable iff (reset)
    mul_req |-> ##(`CORE_MUL_LATENCY) result_valid);

endmodule

//--- hdl/reorder_buffer.sv
`include "core_exec_defs.svh"

module reorder_buffer
(
    // System signals
    input   logic                               clock,
    input   logic                               reset,

    // Allocation
    input   logic                               issue_valid,
    output  logic   [`CORE_ROB_ID_WIDTH-1:0]    alloc_id,
    output  logic                               rob_full,

    // Write port from the ALU
    input   logic                               alu_valid,
    input   core_exec_pkg::exec_result_t        alu_result,

    // Write port from the multiplier
    input   logic                               mul_valid,
    input   core_exec_pkg::exec_result_t        mul_result,

    // In-order retirement
    output  logic                               commit_valid,
    output  core_exec_pkg::commit_t             commit_info
);

//////////////////////////////////////////////////
// Entry state

// Per-entry control bits
logic   [`CORE_ROB_ENTRIES-1:0]     busy;
logic   [`CORE_ROB_ENTRIES-1:0]     done;

// Per-entry payload
logic   [`CORE_REG_ADDR_WIDTH-1:0]  dest_mem [`CORE_ROB_ENTRIES];
logic   [`CORE_DATA_WIDTH-1:0]      data_mem [`CORE_ROB_ENTRIES];

// Oldest and next-free pointers
logic   [`CORE_ROB_ID_WIDTH-1:0]    head;
logic   [`CORE_ROB_ID_WIDTH-1:0]    tail;

// One extra bit to tell full from empty
logic   [`CORE_ROB_ID_WIDTH:0]      count;

logic                               issue_fire;
logic                               retire;

assign rob_full   = (count == `CORE_ROB_ENTRIES);
assign alloc_id   = tail;
assign issue_fire = issue_valid && !rob_full;

// Oldest entry finished
assign retire = busy[head] && done[head];

//////////////////////////////////////////////////
// Control

always_ff @(posedge clock)
begin
    if (reset)
    begin
        busy         <= '0;
        done         <= '0;
        head         <= '0;
        tail         <= '0;
        count        <= '0;
        commit_valid <= 1'b0;
    end
    else
    begin
        // New instruction claims the tail
        if (issue_fire)
        begin
            busy[tail] <= 1'b1;
            done[tail] <= 1'b0;
            tail       <= tail + 1'b1;
        end

        // Results mark their own entry
        if (alu_valid)
            done[alu_result.id] <= 1'b1;
        if (mul_valid)
            done[mul_result.id] <= 1'b1;

        // Free the head on retirement
        if (retire)
        begin
            busy[head] <= 1'b0;
            done[head] <= 1'b0;
            head       <= head + 1'b1;
        end

        case ({issue_fire, retire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase

        commit_valid <= retire;
    end
end

//////////////////////////////////////////////////
// Payload

// Both ports may land in one cycle
always_ff @(posedge clock)
begin
    if (alu_valid)
    begin
        dest_mem[alu_result.id] <= alu_result.dest;
        data_mem[alu_result.id] <= alu_result.data;
    end
    if (mul_valid)
    begin
        dest_mem[mul_result.id] <= mul_result.dest;
        data_mem[mul_result.id] <= mul_result.data;
    end
end

// Registered commit
always_ff @(posedge clock)
begin
    if (retire)
    begin
        commit_info.id   <= head;
        commit_info.dest <= dest_mem[head];
        commit_info.data <= data_mem[head];
    end
end

//////////////////////////////////////////////////
// Checks

// Issuer honors the full level
assert property (@(posedge clock) disable iff (reset)
    issue_valid |-> !rob_full);

// Results only for outstanding, unfinished entries
assert property (@(posedge clock) disable iff (reset)
    alu_valid |-> (busy[alu_result.id] && !done[alu_result.id]));
assert property (@(posedge clock) disable iff (reset)
    mul_valid |-> (busy[mul_result.id] && !done[mul_result.id]));

// Units never race for one entry
assert property (@(posedge clock) disable iff (reset)
    (alu_valid && mul_valid) |-> (alu_result.id != mul_result.id));

endmodule

//--- hdl/core_exec_top.sv
`include "core_exec_defs.svh"

module core_exec_top
(
    // System signals
    input   logic                               clock,
    input   logic                               reset,

    // Issue
    input   logic                               issue_valid,
    input   core_exec_pkg::issue_req_t          issue_info,
    output  logic                               rob_full,
    output  logic   [`CORE_ROB_ID_WIDTH-1:0]    issue_id,

    // Commit
    output  logic                               commit_valid,
    output  core_exec_pkg::commit_t             commit_info
);

//////////////////////////////////////////////////
// Unit results toward the reorder buffer

logic                           alu_valid;
core_exec_pkg::exec_result_t    alu_result;
logic                           mul_valid;
core_exec_pkg::exec_result_t    mul_result;

//////////////////////////////////////////////////
// Reorder buffer, also the id allocator

reorder_buffer
reorder_buffer
(
    .clock          ( clock         ),
    .reset          ( reset         ),
    .issue_valid    ( issue_valid   ),
    .alloc_id       ( issue_id      ),
    .rob_full       ( rob_full      ),
    .alu_valid      ( alu_valid     ),
    .alu_result     ( alu_result    ),
    .mul_valid      ( mul_valid     ),
    .mul_result     ( mul_result    ),
    .commit_valid   ( commit_valid  ),
    .commit_info    ( commit_info   )
);

//////////////////////////////////////////////////
// Execution units side by side

// Single-cycle integer ALU
alu_unit
alu_unit
(
    .clock          ( clock         ),
    .reset          ( reset         ),
    .issue_valid    ( issue_valid   ),
    .issue_info     ( issue_info    ),
    .alloc_id       ( issue_id      ),
    .result_valid   ( alu_valid     ),
    .result         ( alu_result    )
);

// Fixed-latency multiplier
mul_unit
mul_unit
(
    .clock          ( clock         ),
    .reset          ( reset         ),
    .issue_valid    ( issue_valid   ),
    .issue_info     ( issue_info    ),
    .alloc_id       ( issue_id      ),
    .result_valid   ( mul_valid     ),
    .result         ( mul_result    )
);

endmodule

//--- dv/core_exec_tb.sv
`include "core_exec_defs.svh"

module core_exec_tb;

// Test lengths and the run limit
localparam int DIRECTED_COUNT = 12;
localparam int MUL_COUNT      = 12;
localparam int MIX_COUNT      = 40;
localparam int STREAM_COUNT   = 30;
localparam int TOTAL_ISSUES   = DIRECTED_COUNT + MUL_COUNT + MIX_COUNT + STREAM_COUNT;
localparam int CYCLE_LIMIT    = TOTAL_ISSUES * (`CORE_MUL_LATENCY + `CORE_ROB_ENTRIES) + 200;

logic                               clock;
logic                               reset;
logic                               issue_valid;
core_exec_pkg::issue_req_t          issue_info;
logic                               rob_full;
logic   [`CORE_ROB_ID_WIDTH-1:0]    issue_id;
logic                               commit_valid;
core_exec_pkg::commit_t             commit_info;

// Scoreboard state
core_exec_pkg::commit_t             expected_q [$];
core_exec_pkg::commit_t             exp_commit;
integer                             seed;
int                                 errors;
int                                 checks;
int                                 cyc;
int                                 issued_total;
int                                 committed_total;
int                                 outstanding;
int                                 max_outstanding;
int                                 last_commit_cyc;
int                                 max_gap;
int                                 test_errors;
logic                               issue_ok;

core_exec_top dut0
(
    .clock          ( clock         ),
    .reset          ( reset         ),
    .issue_valid    ( issue_valid   ),
    .issue_info     ( issue_info    ),
    .rob_full       ( rob_full      ),
    .issue_id       ( issue_id      ),
    .commit_valid   ( commit_valid  ),
    .commit_info    ( commit_info   )
);

initial
begin
    clock = 1'b0;
    forever #10 clock = ~clock;
end

//////////////////////////////////////////////////
// Reference model and helpers

// Expected data word straight from the opcode rules
function automatic logic [`CORE_DATA_WIDTH-1:0] core_exec_model(
    input core_exec_pkg::issue_req_t req);
    logic   [63:0]  product;
    logic   [4:0]   shamt;
    product = {32'b0, req.src1} * {32'b0, req.src2};
    shamt   = req.src2[4:0];
    if (req.unit == core_exec_pkg::EXEC_MUL)
        return product[31:0];
    case (req.op)
        core_exec_pkg::ALU_ADD: return req.src1 + req.src2;
        core_exec_pkg::ALU_SUB: return req.src1 - req.src2;
        core_exec_pkg::ALU_AND: return req.src1 & req.src2;
        core_exec_pkg::ALU_OR:  return req.src1 | req.src2;
        core_exec_pkg::ALU_XOR: return req.src1 ^ req.src2;
        core_exec_pkg::ALU_SLL: return req.src1 << shamt;
        core_exec_pkg::ALU_SRL: return req.src1 >> shamt;
        core_exec_pkg::ALU_SLT: return ($signed(req.src1) < $signed(req.src2)) ? 32'd1 : 32'd0;
        default:                return '0;
    endcase
endfunction

function automatic core_exec_pkg::issue_req_t make_req(
    input core_exec_pkg::exec_unit_t unit, input core_exec_pkg::alu_op_t op,
    input logic [31:0] a, input logic [31:0] b, input logic [4:0] dest);
    core_exec_pkg::issue_req_t req;
    req.unit = unit;
    req.op   = op;
    req.src1 = a;
    req.src2 = b;
    req.dest = dest;
    return req;
endfunction

// Random request, unit chosen by the caller or at random
function automatic core_exec_pkg::issue_req_t random_req(input int unit_sel);
    logic   [31:0]  rnd;
    core_exec_pkg::exec_unit_t unit;
    rnd  = $random(seed);
    unit = (unit_sel < 0) ? core_exec_pkg::exec_unit_t'(rnd[8])
                          : core_exec_pkg::exec_unit_t'(unit_sel[0]);
    return make_req(unit, core_exec_pkg::alu_op_t'(rnd[2:0]), $random(seed),
                    $random(seed), rnd[20:16]);
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
        $display("FAIL time=%0t %s got %h expected %h", $time, name, actual, expected);
        errors++;
    end
endtask

// Issue one request, held off until the scoreboard allows it
task automatic send(input core_exec_pkg::issue_req_t req);
    logic sent;
    sent = 1'b0;
    while (!sent)
    begin
        @(posedge clock);
        if (issue_ok)
        begin
            issue_valid <= 1'b1;
            issue_info  <= req;
            sent = 1'b1;
        end
        else
            issue_valid <= 1'b0;
    end
endtask

// Directed ALU request
task automatic alu_issue(input core_exec_pkg::alu_op_t op, input logic [31:0] a,
                         input logic [31:0] b, input logic [4:0] dest);
    send(make_req(core_exec_pkg::EXEC_ALU, op, a, b, dest));
endtask

// Stop issuing and wait for every expected commit
task automatic drain();
    @(posedge clock);
    issue_valid <= 1'b0;
    while (expected_q.size() != 0)
        @(negedge clock);
    repeat (3) @(negedge clock);
endtask

task automatic report_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
endtask

//////////////////////////////////////////////////
// Monitor and scoreboard, sampled at the falling edge

always @(negedge clock)
begin
    if (!reset)
    begin
        if (commit_valid)
        begin
            committed_total++;
            if (expected_q.size() == 0)
            begin
                $display("Commit of id %0d arrived with nothing outstanding", commit_info.id);
                errors++;
            end
            else
            begin
                exp_commit = expected_q.pop_front();
                check_value("commit_info.id", commit_info.id, exp_commit.id);
                check_value("commit_info.dest", commit_info.dest, exp_commit.dest);
                check_value("commit_info.data", commit_info.data, exp_commit.data);
            end
            // Spacing between successive commits
            if (last_commit_cyc >= 0 && cyc - last_commit_cyc > max_gap)
                max_gap = cyc - last_commit_cyc;
            last_commit_cyc = cyc;
        end
        // Full exactly when every entry is taken
        outstanding = issued_total - committed_total;
        if (outstanding > max_outstanding)
            max_outstanding = outstanding;
        check_value("rob_full", rob_full, outstanding == `CORE_ROB_ENTRIES);
        // Request pending for the next rising edge
        if (issue_valid)
        begin
            if (rob_full)
            begin
                $display("Issue was presented while the reorder buffer was full");
                errors++;
            end
            check_value("issue_id", issue_id, issued_total % `CORE_ROB_ENTRIES);
            // Ids count up from zero and wrap with the buffer depth
            exp_commit.id   = (`CORE_ROB_ID_WIDTH)'(issued_total % `CORE_ROB_ENTRIES);
            exp_commit.dest = issue_info.dest;
            exp_commit.data = core_exec_model(issue_info);
            expected_q.push_back(exp_commit);
            issued_total++;
        end
        issue_ok = !rob_full && (issued_total - committed_total < `CORE_ROB_ENTRIES);
    end
end

// Cycle counter and run limit
always @(posedge clock)
begin
    cyc = cyc + 1;
    if (cyc >= CYCLE_LIMIT)
    begin
        $display("Run stopped after %0d cycles with %0d commits still expected", cyc,
                 expected_q.size());
        $display("Testbench failed");
        $finish;
    end
end

//////////////////////////////////////////////////
// Test sequence

initial
begin
    seed            = 32'h6bd6;
    reset           = 1'b1;
    issue_valid     = 1'b0;
    issue_info      = '0;
    issue_ok        = 1'b0;
    errors          = 0;
    checks          = 0;
    cyc             = 0;
    issued_total    = 0;
    committed_total = 0;
    max_outstanding = 0;
    last_commit_cyc = -1;
    max_gap         = 0;
    test_errors     = 0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    // Idle after reset
    repeat (4)
    begin
        @(negedge clock);
        check_value("commit_valid", commit_valid, 1'b0);
        check_value("rob_full", rob_full, 1'b0);
        check_value("issue_id", issue_id, 0);
    end
    report_test("idle after reset");

    // Every ALU op, signed compares and wide shift amounts
    alu_issue(core_exec_pkg::ALU_ADD, 32'h7fffffff, 32'd1, 5'd1);
    alu_issue(core_exec_pkg::ALU_SUB, 32'd5, 32'd9, 5'd2);
    alu_issue(core_exec_pkg::ALU_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd3);
    alu_issue(core_exec_pkg::ALU_OR, 32'h8000_0001, 32'h0000_ff00, 5'd4);
    alu_issue(core_exec_pkg::ALU_XOR, 32'haaaa_5555, 32'hffff_0000, 5'd5);
    alu_issue(core_exec_pkg::ALU_SLL, 32'h0000_0003, 32'd31, 5'd6);
    alu_issue(core_exec_pkg::ALU_SLL, 32'h0000_0003, 32'd33, 5'd7);
    alu_issue(core_exec_pkg::ALU_SRL, 32'h8000_0000, 32'd63, 5'd8);
    alu_issue(core_exec_pkg::ALU_SRL, 32'hdead_beef, 32'd32, 5'd9);
    alu_issue(core_exec_pkg::ALU_SLT, -32'sd5, 32'd3, 5'd10);
    alu_issue(core_exec_pkg::ALU_SLT, 32'd3, -32'sd5, 5'd11);
    alu_issue(core_exec_pkg::ALU_SLT, -32'sd7, -32'sd2, 5'd12);
    drain();
    report_test("directed alu");

    // Back-to-back products must retire one per cycle
    last_commit_cyc = -1;
    max_gap         = 0;
    repeat (MUL_COUNT)
        send(random_req(1));
    drain();
    check_value("mul commit gap", max_gap, 1);
    report_test("pipelined mul");

    // ALU right behind a MUL, then a random mix
    send(random_req(1));
    send(random_req(0));
    repeat (MIX_COUNT - 2)
        send(random_req(-1));
    drain();
    report_test("random mix");

    // Continuous issue gated by the full level, ids wrap
    max_outstanding = 0;
    repeat (STREAM_COUNT)
        send(random_req(-1));
    drain();
    check_value("committed count", committed_total, issued_total);
    $display("test stream peak occupancy %0d of %0d", max_outstanding, `CORE_ROB_ENTRIES);
    report_test("full-gated stream");

    if (expected_q.size() != 0)
    begin
        $display("%0d expected commits never arrived", expected_q.size());
        errors++;
    end
    $display("Summary: %0d issued, %0d committed, %0d checks, %0d errors",
             issued_total, committed_total, checks, errors);
    if (errors == 0)
        $display("Testbench passed");
    else
        $display("Testbench failed");
    $finish;
end

endmodule

//--- core_exec.f
+incdir+hdl
hdl/core_exec_pkg.sv
hdl/latency_pipe.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/reorder_buffer.sv
hdl/core_exec_top.sv
dv/core_exec_tb.sv
